// ==== src/execPkg.sv ====
package execPkg;

  // Architectural NZCV, N in the top bit
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // ARM condition field
  typedef enum logic [3:0] {
    EQ = 4'b0000, NE = 4'b0001, // Z set / clear
    CS = 4'b0010, CC = 4'b0011, // C set / clear
    MI = 4'b0100, PL = 4'b0101, // N set / clear
    VS = 4'b0110, VC = 4'b0111, // V set / clear
    HI = 4'b1000, LS = 4'b1001, // Unsigned compares
    GE = 4'b1010, LT = 4'b1011, // Signed compares
    GT = 4'b1100, LE = 4'b1101,
    AL = 4'b1110, NV = 4'b1111  // NV never executes here
  } condT;

  // Data-processing opcodes in architectural order
  typedef enum logic [3:0] {
    AND = 4'h0, EOR = 4'h1, SUB = 4'h2, RSB = 4'h3,
    ADD = 4'h4, ADC = 4'h5, SBC = 4'h6, RSC = 4'h7,
    TST = 4'h8, TEQ = 4'h9, CMP = 4'ha, CMN = 4'hb,
    ORR = 4'hc, MOV = 4'hd, BIC = 4'he, MVN = 4'hf
  } aluOpT;

  // Immediate shift kinds
  typedef enum logic [1:0] {
    LSL = 2'b00,
    LSR = 2'b01,
    ASR = 2'b10,
    ROR = 2'b11
  } shiftT;

  // Where C and V come from on a flag update
  typedef enum logic {
    cvLogic = 1'b0, // C from shifter, V kept
    cvArith = 1'b1  // C and V from the adder
  } cvClassT;

endpackage

// ==== src/flagBus.sv ====
`timescale 1ns/1ps

interface flagBus import execPkg::*; ();

  flagsT   aluFlags;     // NZCV from the ALU
  cvClassT cvClass;      // How C and V update
  logic    [1:0] multFlags; // {N, Z} from the multiplier
  logic    shifterCarry; // Last bit out of the shifter
  logic    multSelect;   // Instruction is a multiply

  modport aluSide (output aluFlags, output cvClass);
  modport multSide (output multFlags);
  modport shiftSide (output shifterCarry);

  // Condition unit sees every flag source
  modport condSide (
    input aluFlags,
    input cvClass,
    input multFlags,
    input shifterCarry,
    input multSelect
  );

endinterface

// ==== src/barrelShifter.sv ====
`timescale 1ns/1ps

module barrelShifter import execPkg::*; #(
  parameter int dataWidth = 32
) (
  input  logic [dataWidth-1:0] opB,
  input  shiftT                shiftType,
  input  logic [4:0]           shiftAmount,
  input  logic                 carryIn,     // Old C, used for amount 0
  output logic [dataWidth-1:0] operand2,
  flagBus.shiftSide            fb
);

  logic        [dataWidth:0]   lslExt;  // Carry sits above the result
  logic        [dataWidth:0]   lsrExt;  // Carry sits below the result
  logic signed [dataWidth:0]   asrExt;
  logic        [4:0]           rotAmt;
  logic        [dataWidth-1:0] rotated;

  // Extra bit catches the last bit shifted out
  assign lslExt = {1'b0, opB} << shiftAmount;
  assign lsrExt = {opB, 1'b0} >> shiftAmount;
  assign asrExt = $signed({opB, 1'b0}) >>> shiftAmount; // Sign fill past the width

  // Rotate wraps at the data width
  assign rotAmt  = 5'(shiftAmount % dataWidth);
  assign rotated = (opB >> rotAmt) | (opB << (dataWidth - rotAmt));

  always_comb begin
    operand2        = opB;
    fb.shifterCarry = carryIn;
    if (shiftAmount != 5'd0) begin // Zero amount passes opB and old C
      unique case (shiftType)
        LSL: begin
          operand2        = lslExt[dataWidth-1:0];
          fb.shifterCarry = lslExt[dataWidth];
        end
        LSR: begin
          operand2        = lsrExt[dataWidth:1];
          fb.shifterCarry = lsrExt[0];
        end
        ASR: begin
          operand2        = asrExt[dataWidth:1];
          fb.shifterCarry = asrExt[0];
        end
        ROR: begin
          operand2        = rotated;
          fb.shifterCarry = rotated[dataWidth-1]; // Bit that wrapped into the top
        end
      endcase
    end
  end

endmodule

// ==== src/dataProcAlu.sv ====
`timescale 1ns/1ps

module dataProcAlu import execPkg::*; #(
  parameter int dataWidth = 32
) (
  input  logic [dataWidth-1:0] opA,
  input  logic [dataWidth-1:0] operand2,
  input  aluOpT                aluOp,
  input  logic                 carryIn,   // C flag for ADC, SBC, RSC
  output logic [dataWidth-1:0] aluResult,
  flagBus.aluSide              fb
);

  logic [dataWidth-1:0] addA;
  logic [dataWidth-1:0] addB;
  logic                 addCin;
  logic [dataWidth:0]   sum;      // Top bit is the adder carry
  logic                 addV;
  cvClassT              cvClass;

  // Adder operands, subtraction as A + ~B + 1
  always_comb begin
    addA    = opA;
    addB    = operand2;
    addCin  = 1'b0;
    cvClass = cvArith;
    unique case (aluOp)
      SUB, CMP: begin
        addB   = ~operand2;
        addCin = 1'b1;
      end
      RSB: begin
        addA   = operand2;
        addB   = ~opA;
        addCin = 1'b1;
      end
      ADD, CMN: addCin = 1'b0;
      ADC: addCin = carryIn;
      SBC: begin
        addB   = ~operand2;
        addCin = carryIn; // C clear means borrow
      end
      RSC: begin
        addA   = operand2;
        addB   = ~opA;
        addCin = carryIn;
      end
      default: cvClass = cvLogic; // Logical ops and moves
    endcase
  end

  assign sum  = {1'b0, addA} + {1'b0, addB} + {{dataWidth{1'b0}}, addCin};
  // Signed overflow when like-signed inputs give an opposite-signed sum
  assign addV = (addA[dataWidth-1] == addB[dataWidth-1]) &&
                (sum[dataWidth-1] != addA[dataWidth-1]);

  always_comb begin
    unique case (aluOp)
      AND, TST: aluResult = opA & operand2;
      EOR, TEQ: aluResult = opA ^ operand2;
      ORR:      aluResult = opA | operand2;
      MOV:      aluResult = operand2;
      BIC:      aluResult = opA & ~operand2;
      MVN:      aluResult = ~operand2;
      default:  aluResult = sum[dataWidth-1:0]; // All adder ops
    endcase
  end

  assign fb.aluFlags.n = aluResult[dataWidth-1];
  assign fb.aluFlags.z = (aluResult == '0);
  assign fb.aluFlags.c = sum[dataWidth]; // Not-borrow on subtracts
  assign fb.aluFlags.v = addV;
  assign fb.cvClass    = cvClass;

endmodule

// ==== src/multiplyUnit.sv ====
`timescale 1ns/1ps

module multiplyUnit import execPkg::*; #(
  parameter int dataWidth = 32
) (
  input  logic [dataWidth-1:0] opA,
  input  logic [dataWidth-1:0] opB,
  input  logic [dataWidth-1:0] opAcc,      // Addend for MLA
  input  logic                 accumulate, // MLA when set, MUL otherwise
  output logic [dataWidth-1:0] multResult,
  flagBus.multSide             fb
);

  logic [dataWidth-1:0] product; // Low half only
  logic [dataWidth-1:0] addend;

  assign product = opA * opB;
  assign addend  = accumulate ? opAcc : '0;

  assign multResult = product + addend; // Wraps like the hardware

  // N from the top bit, Z from the whole word
  assign fb.multFlags[1] = multResult[dataWidth-1];
  assign fb.multFlags[0] = (multResult == '0);

endmodule

// ==== src/conditionUnit.sv ====
`timescale 1ns/1ps

module conditionUnit import execPkg::*; (
  input  condT  cond,
  input  flagsT flags,     // Registered flags
  input  logic  setFlags,  // S bit
  input  logic  issue,
  output logic  condEx,    // Instruction executes
  output flagsT flagsNext, // Value for the flag register
  flagBus.condSide fb
);

  logic ge;
  logic negNext;
  logic zeroNext;
  logic carryNext;
  logic overflowNext;
  logic updateNz;
  logic updateCv;

  assign ge = (flags.n == flags.v); // Signed greater or equal

  always_comb begin
    unique case (cond)
      EQ: condEx = flags.z;
      NE: condEx = ~flags.z;
      CS: condEx = flags.c;
      CC: condEx = ~flags.c;
      MI: condEx = flags.n;
      PL: condEx = ~flags.n;
      VS: condEx = flags.v;
      VC: condEx = ~flags.v;
      HI: condEx = flags.c & ~flags.z;
      LS: condEx = ~flags.c | flags.z;
      GE: condEx = ge;
      LT: condEx = ~ge;
      GT: condEx = ~flags.z & ge;
      LE: condEx = flags.z | ~ge;
      AL: condEx = 1'b1;
      NV: condEx = 1'b0; // Never execute
    endcase
  end

  // N and Z follow whichever unit produced the result
  assign negNext  = fb.multSelect ? fb.multFlags[1] : fb.aluFlags.n;
  assign zeroNext = fb.multSelect ? fb.multFlags[0] : fb.aluFlags.z;

  // Logical ops take the shifter carry
  assign carryNext = (fb.cvClass == cvLogic) ? fb.shifterCarry : fb.aluFlags.c;

  // V untouched by logical ops and multiplies
  assign overflowNext = (fb.cvClass == cvLogic || fb.multSelect) ? flags.v
                                                                  : fb.aluFlags.v;

  assign updateNz = issue & setFlags & condEx;
  assign updateCv = updateNz & ~fb.multSelect; // Multiply leaves C and V

  always_comb begin
    flagsNext = flags; // Hold unless written
    if (updateNz) begin
      flagsNext.n = negNext;
      flagsNext.z = zeroNext;
    end
    if (updateCv) begin
      flagsNext.c = carryNext;
      flagsNext.v = overflowNext;
    end
  end

endmodule

// ==== src/executeStage.sv ====
`timescale 1ns/1ps

module executeStage import execPkg::*; #(
  parameter int dataWidth = 32
) (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 issue,       // One-cycle strobe
  input  condT                 cond,
  input  aluOpT                aluOp,
  input  logic                 setFlags,
  input  logic                 isMult,
  input  logic                 accumulate,
  input  logic [dataWidth-1:0] opA,
  input  logic [dataWidth-1:0] opB,
  input  logic [dataWidth-1:0] opAcc,
  input  shiftT                shiftType,
  input  logic [4:0]           shiftAmount,
  output logic                 retired,     // Pulse one cycle after issue
  output logic                 executed,    // Valid with retired
  output logic [dataWidth-1:0] result,
  output flagsT                flags        // Architectural NZCV
);

  logic [dataWidth-1:0] operand2;
  logic [dataWidth-1:0] aluResult;
  logic [dataWidth-1:0] multResult;
  logic [dataWidth-1:0] resultNext;
  logic                 condEx;
  flagsT                flagsNext;

  flagBus fb();

  assign fb.multSelect = isMult;

  barrelShifter #(.dataWidth(dataWidth)) uShifter (
    .opB         (opB),
    .shiftType   (shiftType),
    .shiftAmount (shiftAmount),
    .carryIn     (flags.c),
    .operand2    (operand2),
    .fb          (fb.shiftSide)
  );

  dataProcAlu #(.dataWidth(dataWidth)) uAlu (
    .opA       (opA),
    .operand2  (operand2),
    .aluOp     (aluOp),
    .carryIn   (flags.c),
    .aluResult (aluResult),
    .fb        (fb.aluSide)
  );

  multiplyUnit #(.dataWidth(dataWidth)) uMult (
    .opA        (opA),
    .opB        (opB),       // Multiplier bypasses the shifter
    .opAcc      (opAcc),
    .accumulate (accumulate),
    .multResult (multResult),
    .fb         (fb.multSide)
  );

  conditionUnit uCond (
    .cond      (cond),
    .flags     (flags),
    .setFlags  (setFlags),
    .issue     (issue),
    .condEx    (condEx),
    .flagsNext (flagsNext),
    .fb        (fb.condSide)
  );

  assign resultNext = isMult ? multResult : aluResult;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      retired  <= 1'b0;
      executed <= 1'b0;
      result   <= '0;
      flags    <= '0;
    end else begin
      retired  <= issue;
      executed <= issue & condEx;
      if (issue && condEx) result <= resultNext; // Compares still load
      flags    <= flagsNext; // Passes through when not updating
    end
  end

endmodule

// ==== verification/tbExecuteStage.sv ====
`timescale 1ns/1ps

module tbExecuteStage import execPkg::*; ();

  logic        clk;
  logic        arstN;
  logic        issue;
  condT        cond;
  aluOpT       aluOp;
  logic        setFlags;
  logic        isMult;
  logic        accumulate;
  logic [31:0] opA;
  logic [31:0] opB;
  logic [31:0] opAcc;
  shiftT       shiftType;
  logic [4:0]  shiftAmount;
  logic        retired;
  logic        executed;
  logic [31:0] result;
  flagsT       flags;

  logic [31:0] lfsrState;
  flagsT       modelFlags;  // Expected NZCV
  logic [31:0] modelResult; // Expected result register
  logic        modelEx;     // Expected executed

  executeStage #(.dataWidth(32)) DUT (.*);

  always #10 clk = ~clk; // 20 ns period

  // Galois LFSR, one step per bit taken
  function automatic logic nextBit();
    logic outBit;
    outBit = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit) lfsrState = lfsrState ^ 32'h80200003; // x^32+x^22+x^2+x+1
    return outBit;
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] value;
    value = 32'h0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], nextBit()};
    end
    return value;
  endfunction

  // Condition table, odd codes negate the even code below
  function automatic logic condHolds(input condT c, input flagsT f);
    logic base;
    if (c == AL || c == NV) return (c == AL);
    case (c[3:1])
      3'd0: base = f.z;
      3'd1: base = f.c;
      3'd2: base = f.n;
      3'd3: base = f.v;
      3'd4: base = f.c & ~f.z;           // HI
      3'd5: base = (f.n == f.v);         // GE
      default: base = ~f.z & (f.n == f.v); // GT
    endcase
    return base ^ c[0];
  endfunction

  task automatic checkFlags(input string name, input flagsT got, input flagsT exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, 4'(got), 4'(exp));
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic checkResult(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  // Reference model for the fields on the inputs, advances the model state
  task automatic predict();
    logic [31:0] op2;
    logic        shC;  // Last bit shifted out
    logic [63:0] ua;
    logic [63:0] ub;
    logic [63:0] sa;   // Sign-extended copies
    logic [63:0] sb;
    logic [63:0] ur;   // Exact unsigned result
    logic [63:0] sr;   // Exact signed result
    logic [63:0] prod;
    logic [31:0] res;
    logic        arith;
    logic        sub;
    flagsT       f;
    f = modelFlags;
    op2 = opB;
    shC = f.c; // Amount 0 keeps the old C
    for (int i = 0; i < int'(shiftAmount); i++) begin
      case (shiftType) // One bit at a time
        LSL: {shC, op2} = {op2, 1'b0};
        LSR: {op2, shC} = {1'b0, op2};
        ASR: {op2, shC} = {op2[31], op2};
        default: {op2, shC} = {op2[0], op2}; // ROR
      endcase
    end
    ua = {32'h0, opA};
    ub = {32'h0, op2};
    sa = {{32{opA[31]}}, opA};
    sb = {{32{op2[31]}}, op2};
    arith = aluOp inside {SUB, RSB, ADD, ADC, SBC, RSC, CMP, CMN};
    sub = aluOp inside {SUB, RSB, SBC, RSC, CMP}; // C is not-borrow
    case (aluOp)
      AND, TST: res = opA & op2;
      EOR, TEQ: res = opA ^ op2;
      ORR:      res = opA | op2;
      MOV:      res = op2;
      BIC:      res = opA & ~op2;
      MVN:      res = ~op2;
      ADD, CMN: {ur, sr} = {ua + ub, sa + sb};
      ADC:      {ur, sr} = {ua + ub + 64'(f.c), sa + sb + 64'(f.c)};
      SUB, CMP: {ur, sr} = {ua - ub, sa - sb};
      RSB:      {ur, sr} = {ub - ua, sb - sa};
      SBC:      {ur, sr} = {ua - ub - 64'(!f.c), sa - sb - 64'(!f.c)};
      default:  {ur, sr} = {ub - ua - 64'(!f.c), sb - sa - 64'(!f.c)}; // RSC
    endcase
    if (arith) res = ur[31:0];
    prod = {32'h0, opA} * {32'h0, opB}; // Multiplier sees unshifted opB
    if (isMult) res = prod[31:0] + (accumulate ? opAcc : 32'h0);
    modelEx = condHolds(cond, f);
    if (modelEx) modelResult = res;
    if (modelEx && setFlags) begin
      modelFlags.n = res[31];
      modelFlags.z = (res == 32'h0);
      if (!isMult) begin // Multiply keeps C and V
        modelFlags.c = arith ? (sub ? ~ur[63] : ur[32]) : shC;
        modelFlags.v = arith ? (sr != {{32{res[31]}}, res}) : f.v;
      end
    end
  endtask

  // Drives one instruction on a falling edge and checks its retirement
  task automatic issueInstr(input condT c, input aluOpT op, input logic s, input logic m,
                            input logic acc, input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] ac, input shiftT st, input logic [4:0] amt);
    int waitCnt;
    cond = c;
    aluOp = op;
    setFlags = s;
    isMult = m;
    accumulate = acc;
    opA = a;
    opB = b;
    opAcc = ac;
    shiftType = st;
    shiftAmount = amt;
    issue = 1'b1;
    predict();
    waitCnt = 0;
    @(negedge clk);
    issue = 1'b0; // Next call may raise it again right away
    while (retired !== 1'b1) begin
      if (waitCnt == 4) begin
        $display("Timed out waiting for retired");
        $display("TEST FAILED");
        $fatal(1);
      end
      waitCnt++;
      @(negedge clk);
    end
    checkBit("executed", executed, modelEx);
    checkResult("result", result, modelResult);
    checkFlags("flags", flags, modelFlags);
  endtask

  task automatic testReset();
    checkFlags("flags", flags, flagsT'(4'h0));
    checkResult("result", result, 32'h0);
    checkBit("executed", executed, 1'b0);
    repeat (4) begin // No issue, no retirement
      checkBit("retired", retired, 1'b0);
      @(negedge clk);
    end
  endtask

  task automatic testArith();
    issueInstr(AL, ADD, 1'b1, 1'b0, 1'b0, 32'h7fffffff, 32'h1, 32'h0, LSL, 5'd0);
    checkFlags("flags", flags, flagsT'(4'b1001)); // Positive overflow
    issueInstr(AL, ADD, 1'b1, 1'b0, 1'b0, 32'h80000000, 32'h80000000, 32'h0, LSL, 5'd0);
    checkFlags("flags", flags, flagsT'(4'b0111)); // Zero with carry and overflow
    issueInstr(AL, SUB, 1'b1, 1'b0, 1'b0, 32'h3, 32'h5, 32'h0, LSL, 5'd0);
    checkFlags("flags", flags, flagsT'(4'b1000)); // Borrow clears C
    issueInstr(AL, ADC, 1'b1, 1'b0, 1'b0, 32'h1, 32'h1, 32'h0, LSL, 5'd0);
    checkResult("result", result, 32'h2);
    issueInstr(AL, SUB, 1'b1, 1'b0, 1'b0, 32'h5, 32'h3, 32'h0, LSL, 5'd0);
    issueInstr(AL, ADC, 1'b1, 1'b0, 1'b0, 32'h1, 32'h1, 32'h0, LSL, 5'd0);
    checkResult("result", result, 32'h3); // Takes C
    issueInstr(AL, SBC, 1'b1, 1'b0, 1'b0, 32'h5, 32'h3, 32'h0, LSL, 5'd0);
    checkResult("result", result, 32'h1); // C clear, extra borrow
    issueInstr(AL, RSB, 1'b1, 1'b0, 1'b0, 32'h2, 32'h7, 32'h0, LSL, 5'd0);
    issueInstr(AL, RSC, 1'b1, 1'b0, 1'b0, 32'h1, 32'h0, 32'h0, LSL, 5'd0);
    issueInstr(AL, CMP, 1'b1, 1'b0, 1'b0, 32'h7, 32'h7, 32'h0, LSL, 5'd0);
    checkFlags("flags", flags, flagsT'(4'b0110));
    issueInstr(AL, ADD, 1'b0, 1'b0, 1'b0, 32'h7fffffff, 32'h1, 32'h0, LSL, 5'd0);
    checkFlags("flags", flags, flagsT'(4'b0110)); // S clear
  endtask

  task automatic testLogic();
    aluOpT      ops[5] = '{AND, ORR, MOV, MVN, TST};
    shiftT      kinds[4] = '{LSL, LSR, ASR, ROR};
    logic [4:0] amts[3] = '{5'd0, 5'd1, 5'd31};
    issueInstr(AL, CMP, 1'b1, 1'b0, 1'b0, 32'h80000000, 32'h1, 32'h0, LSL, 5'd0); // V set
    foreach (ops[i]) begin
      foreach (kinds[t]) begin
        foreach (amts[k]) begin
          issueInstr(AL, ops[i], 1'b1, 1'b0, 1'b0, randBits(32), randBits(32), 32'h0,
                     kinds[t], amts[k]);
          checkBit("flags.v", flags.v, 1'b1);
        end
      end
    end
  endtask

  // Flag states 0110, 1000, 0011, 0010, 1001 from the CMP pairs
  task automatic testCond();
    logic [31:0] cmpA[5] = '{32'h0, 32'h0, 32'h80000000, 32'h1, 32'h7fffffff};
    logic [31:0] cmpB[5] = '{32'h0, 32'h1, 32'h1, 32'h0, 32'hffffffff};
    for (int c = 0; c < 16; c++) begin
      foreach (cmpA[k]) begin
        issueInstr(AL, MOV, 1'b0, 1'b0, 1'b0, 32'h0, {28'h5a5a5a5, c[3:0]}, 32'h0, LSL, 5'd0);
        issueInstr(AL, CMP, 1'b1, 1'b0, 1'b0, cmpA[k], cmpB[k], 32'h0, LSL, 5'd0);
        issueInstr(condT'(c[3:0]), ADD, 1'b1, 1'b0, 1'b0, 32'h1, 32'h2, 32'h0, LSL, 5'd0);
      end
    end
  endtask

  task automatic testMult();
    issueInstr(AL, CMP, 1'b1, 1'b0, 1'b0, 32'h80000000, 32'h1, 32'h0, LSL, 5'd0); // C and V set
    issueInstr(AL, ADD, 1'b1, 1'b1, 1'b0, 32'h10000, 32'h10000, 32'h0, LSL, 5'd0);
    checkFlags("flags", flags, flagsT'(4'b0111)); // Low word is zero
    issueInstr(AL, ADD, 1'b1, 1'b1, 1'b1, 32'hfffffffd, 32'h7, 32'h5, LSL, 5'd3);
    checkResult("result", result, 32'hfffffff0); // -21 + 5
    checkFlags("flags", flags, flagsT'(4'b1011));
    repeat (8) begin
      issueInstr(AL, ADD, 1'b1, 1'b1, 1'(randBits(1)), randBits(32), randBits(32),
                 randBits(32), LSL, 5'd0);
    end
  endtask

  task automatic testRandom();
    repeat (200) begin // Issue every cycle
      issueInstr(condT'(4'(randBits(4))), aluOpT'(4'(randBits(4))), 1'(randBits(1)),
                 1'(randBits(1)), 1'(randBits(1)), randBits(32), randBits(32), randBits(32),
                 shiftT'(2'(randBits(2))), 5'(randBits(5)));
    end
  endtask

  initial begin
    clk = 1'b0;
    arstN = 1'b0;
    issue = 1'b0;
    cond = AL;
    aluOp = AND;
    setFlags = 1'b0;
    isMult = 1'b0;
    accumulate = 1'b0;
    opA = 32'h0;
    opB = 32'h0;
    opAcc = 32'h0;
    shiftType = LSL;
    shiftAmount = 5'd0;
    lfsrState = 32'hfc18;
    modelFlags = flagsT'(4'h0);
    modelResult = 32'h0;
    modelEx = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
    testReset();
    testArith();
    testLogic();
    testCond();
    testMult();
    testRandom();
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== verilog.f ====
src/execPkg.sv
src/flagBus.sv
src/barrelShifter.sv
src/dataProcAlu.sv
src/multiplyUnit.sv
src/conditionUnit.sv
src/executeStage.sv
verification/tbExecuteStage.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timescale 1ns/1ps -f verilog.f --top-module tbExecuteStage
out=$(./obj_dir/VtbExecuteStage || true)
echo "$out"
echo "$out" | grep -q "TEST OK"
